//--- tb.f
hw/rv_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/exec_unit.sv
hw/int_core.sv
dv/tb_clock_gen.sv
dv/tb_int_core.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
  --top-module tb_int_core -f tb.f -o tb_int_core_sim &&
  ./obj_dir/tb_int_core_sim | grep -x "TEST OK" ||
  { echo "simulation failed"; exit 1; }

//--- dv/tb_int_core.sv
module tb_int_core
  import rv_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int reset_cycles = 10;
  localparam int max_gap = 3;
  localparam int stall_allow = 8;
  localparam int n_init = 31;
  localparam int n_alu = 400;
  localparam int n_lui = 30;
  localparam int n_zero = 30;
  localparam int n_bad = 40;
  localparam int n_read = 32;
  localparam int n_total = n_init + n_alu + n_lui + n_zero + n_bad + n_read;
  localparam int cycle_limit = n_total * (2 + max_gap + stall_allow) + reset_cycles;

  logic            clock;
  logic            reset;
  logic [31:0]     inst;
  logic            ivalid;
  logic            iready;
  logic            stall;
  logic            retire_valid;
  logic [4:0]      retire_rd;
  logic [xlen-1:0] retire_data;
  logic            retire_wen;

  // reference state and expected retires in program order
  logic [xlen-1:0] model_regs [0:31];
  string           exp_name[$];
  logic [4:0]      exp_rd[$];
  logic [xlen-1:0] exp_data[$];
  logic            exp_wen[$];
  logic            exp_known[$];

  int   mismatch_count;
  int   fault_count;
  int   cycles;
  logic stall_seen;

  tb_clock_gen u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  int_core u_int_core (
    .clock        (clock),
    .reset        (reset),
    .inst         (inst),
    .ivalid       (ivalid),
    .iready       (iready),
    .stall        (stall),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .retire_wen   (retire_wen)
  );

  task automatic check_word(input string name, input logic [xlen-1:0] expected,
                            input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_index(input string name, input logic [4:0] expected,
                             input logic [4:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected x%0d, actual x%0d", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected %b, actual %b", name, expected, actual);
      mismatch_count++;
    end
  endtask

  // ISA rules for LUI, OP-IMM and OP, everything else is unsupported
  function automatic void predict(input logic [31:0] w, output logic [xlen-1:0] data,
                                  output logic wen, output logic known);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [2:0]      f3;
    logic [6:0]      f7;
    a = model_regs[w[19:15]];
    f3 = w[14:12];
    f7 = w[31:25];
    known = 1'b1;
    data = '0;
    if (w[6:0] == opcode_op) begin
      b = model_regs[w[24:20]];
    end else begin
      b = {{20{w[31]}}, w[31:20]};
    end
    case (w[6:0])
      opcode_lui: begin
        data = {w[31:12], 12'b0};
      end
      opcode_op, opcode_op_imm: begin
        // funct7 only matters for OP and for immediate shifts
        if (w[6:0] == opcode_op || f3 == 3'b001 || f3 == 3'b101) begin
          known = (f7 == funct7_base) ||
                  (f7 == funct7_alt && (f3 == 3'b101 || f3 == 3'b000));
        end
        case (f3)
          3'b000: data = (w[6:0] == opcode_op && f7 == funct7_alt) ? a - b : a + b;
          3'b001: data = a << b[4:0];
          3'b010: data = xlen'($signed(a) < $signed(b));
          3'b011: data = xlen'(a < b);
          3'b100: data = a ^ b;
          3'b101: begin
            if (f7 == funct7_alt) begin
              data = $signed(a) >>> b[4:0];
            end else begin
              data = a >> b[4:0];
            end
          end
          3'b110: data = a | b;
          default: data = a & b;
        endcase
      end
      default: begin
        known = 1'b0;
      end
    endcase
    wen = known && (w[11:7] != 5'd0);
    if (wen) begin
      model_regs[w[11:7]] = data;
    end
  endfunction

  function automatic logic [31:0] op_imm_word(input logic [11:0] imm12, input logic [4:0] rs,
                                              input logic [4:0] rd);
    return {imm12, rs, 3'b000, rd, opcode_op_imm};
  endfunction

  // random legal OP or OP-IMM word with a nonzero rd
  function automatic logic [31:0] rand_alu_word();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [6:0]  f7;
    r = $urandom();
    f3 = r[14:12];
    rd = 5'($urandom_range(31, 1));
    f7 = (r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? funct7_alt : funct7_base;
    if (r[0]) begin
      return {f7, r[24:15], f3, rd, opcode_op};
    end
    if (f3 == 3'b001) begin
      return {funct7_base, r[24:15], f3, rd, opcode_op_imm};
    end
    if (f3 == 3'b101) begin
      return {f7, r[24:15], f3, rd, opcode_op_imm};
    end
    return {r[31:15], f3, rd, opcode_op_imm};
  endfunction

  // loads, stores, branches, system and OP with an illegal funct7
  function automatic logic [31:0] bad_word();
    logic [31:0] r;
    logic [31:0] w;
    logic [6:0]  f7;
    r = $urandom();
    f7 = 7'($urandom_range(127, 33));
    case ($urandom_range(4, 0))
      0: w = {r[31:7], 7'b0000011};
      1: w = {r[31:7], 7'b0100011};
      2: w = {r[31:7], 7'b1100011};
      3: w = {r[31:7], 7'b1110011};
      default: w = {f7, r[24:7], opcode_op};
    endcase
    return w;
  endfunction

  task automatic send_inst(input string name, input logic [31:0] word);
    int              gap;
    logic [xlen-1:0] data;
    logic            wen;
    logic            known;
    gap = $urandom_range(max_gap, 0);
    repeat (gap) @(posedge clock);
    @(posedge clock);
    inst <= word;
    ivalid <= 1'b1;
    @(negedge clock);
    while (!iready) @(negedge clock);
    @(posedge clock);
    ivalid <= 1'b0;
    // accepted on this edge
    predict(word, data, wen, known);
    exp_name.push_back(name);
    exp_rd.push_back(word[11:7]);
    exp_data.push_back(data);
    exp_wen.push_back(wen);
    exp_known.push_back(known);
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
    if (mismatch_count == 0 && fault_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // stall is high about one cycle in four
  initial begin
    stall = 1'b0;
    forever begin
      @(posedge clock);
      stall <= reset ? 1'b0 : ($urandom_range(3, 0) == 0);
    end
  end

  // retire monitor, sampled mid-cycle
  initial begin
    string name;
    stall_seen = 1'b0;
    forever begin
      @(negedge clock);
      if (!reset && retire_valid) begin
        if (exp_rd.size() == 0) begin
          $display("retire seen with no instruction in flight");
          fault_count++;
        end else begin
          name = exp_name.pop_front();
          check_index({name, " rd"}, exp_rd.pop_front(), retire_rd);
          check_bit({name, " wen"}, exp_wen.pop_front(), retire_wen);
          if (exp_known.pop_front()) begin
            check_word({name, " data"}, exp_data[0], retire_data);
          end
          void'(exp_data.pop_front());
        end
        if (stall_seen) begin
          $display("retire came from an edge where stall was high");
          fault_count++;
        end
      end
      if (!reset && exp_rd.size() != 0 && iready) begin
        $display("iready high while an instruction is in flight");
        fault_count++;
      end
      stall_seen = stall;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: retires missing");
    fault_count++;
    finish_run();
  end

  initial begin
    logic [31:0] w;
    inst = '0;
    ivalid = 1'b0;
    mismatch_count = 0;
    fault_count = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    void'($urandom(3));
    @(negedge clock);
    while (reset) @(negedge clock);
    check_bit("reset iready", 1'b1, iready);
    check_bit("reset retire_valid", 1'b0, retire_valid);
    for (int i = 1; i < 32; i++) begin
      w = $urandom();
      send_inst("init", op_imm_word(w[11:0], 5'd0, 5'(i)));
    end
    for (int i = 0; i < n_alu; i++) begin
      send_inst("alu", rand_alu_word());
    end
    for (int i = 0; i < n_lui; i++) begin
      w = $urandom();
      send_inst("lui", {w[31:12], 5'($urandom_range(31, 1)), opcode_lui});
    end
    for (int i = 0; i < n_zero; i++) begin
      w = rand_alu_word();
      if (w[31]) begin
        w[6:0] = opcode_lui;
      end
      w[11:7] = 5'd0;
      send_inst("x0", w);
    end
    for (int i = 0; i < n_bad; i++) begin
      send_inst("unsupported", bad_word());
    end
    // read back every register, x0 included
    for (int i = 0; i < 32; i++) begin
      send_inst("readback", op_imm_word(12'd0, 5'(i), 5'(i)));
    end
    while (exp_rd.size() != 0) @(negedge clock);
    repeat (3) @(negedge clock);
    finish_run();
  end

endmodule

//--- dv/tb_clock_gen.sv
module tb_clock_gen (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int reset_cycles = 10;

  // 8 ns period
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

//--- hw/int_core.sv
module int_core
  import rv_pkg::*;
(
  input  logic            clock,
  input  logic            reset,

  input  logic [31:0]     inst,
  input  logic            ivalid,
  output logic            iready,

  input  logic            stall,

  output logic            retire_valid,
  output logic [4:0]      retire_rd,
  output logic [xlen-1:0] retire_data,
  output logic            retire_wen
);

  // decoder to execute
  logic            dvalid;
  logic            dready;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [xlen-1:0] imm;
  alu_op_t         alu_op;
  operand_b_sel_t  operand_b_sel;
  logic            r_wen;

  // register file and alu
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  alu_op_t         alu_op_exec;
  logic [xlen-1:0] alu_result;
  logic            wen;
  logic [4:0]      waddr;
  logic [xlen-1:0] wdata;

  inst_decoder u_decoder (
    .clock         (clock),
    .reset         (reset),
    .inst          (inst),
    .ivalid        (ivalid),
    .iready        (iready),
    .dvalid        (dvalid),
    .dready        (dready),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .imm           (imm),
    .alu_op        (alu_op),
    .operand_b_sel (operand_b_sel),
    .r_wen         (r_wen)
  );

  // read indices go straight from the decoder
  reg_file u_regs (
    .clock  (clock),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (wen),
    .waddr  (waddr),
    .wdata  (wdata)
  );

  alu u_alu (
    .op     (alu_op_exec),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  exec_unit u_exec (
    .clock         (clock),
    .reset         (reset),
    .dvalid        (dvalid),
    .dready        (dready),
    .stall         (stall),
    .rd            (rd),
    .imm           (imm),
    .alu_op        (alu_op),
    .operand_b_sel (operand_b_sel),
    .r_wen         (r_wen),
    .rdata1        (rdata1),
    .rdata2        (rdata2),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .alu_op_out    (alu_op_exec),
    .alu_result    (alu_result),
    .wen           (wen),
    .waddr         (waddr),
    .wdata         (wdata),
    .retire_valid  (retire_valid),
    .retire_rd     (retire_rd),
    .retire_data   (retire_data),
    .retire_wen    (retire_wen)
  );

endmodule

//--- hw/exec_unit.sv
module exec_unit
  import rv_pkg::*;
(
  input  logic            clock,
  input  logic            reset,

  input  logic            dvalid,
  output logic            dready,
  input  logic            stall,

  input  logic [4:0]      rd,
  input  logic [xlen-1:0] imm,
  input  alu_op_t         alu_op,
  input  operand_b_sel_t  operand_b_sel,
  input  logic            r_wen,

  input  logic [xlen-1:0] rdata1,
  input  logic [xlen-1:0] rdata2,

  output logic [xlen-1:0] alu_a,
  output logic [xlen-1:0] alu_b,
  output alu_op_t         alu_op_out,
  input  logic [xlen-1:0] alu_result,

  output logic            wen,
  output logic [4:0]      waddr,
  output logic [xlen-1:0] wdata,

  output logic            retire_valid,
  output logic [4:0]      retire_rd,
  output logic [xlen-1:0] retire_data,
  output logic            retire_wen
);

  logic transfer;

  assign dready   = !stall;
  assign transfer = dvalid && dready;

  // operand routing into the alu
  assign alu_a      = rdata1;
  assign alu_b      = (operand_b_sel == reg_b) ? rdata2 : imm;
  assign alu_op_out = alu_op;

  // write back only on the edge that takes the item
  assign wen   = transfer && r_wen;
  assign waddr = rd;
  assign wdata = alu_result;

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= transfer;
    end
  end

  always_ff @(posedge clock) begin
    if (transfer) begin
      retire_rd   <= rd;
      retire_data <= alu_result;
      retire_wen  <= r_wen;
    end
  end

  // the decoder needs a fresh accept between items, so retires are spaced
  a_retire_single: assert property (
    @(posedge clock) disable iff (reset) retire_valid |=> !retire_valid
  );

endmodule

//--- hw/alu.sv
module alu
  import rv_pkg::*;
(
  input  alu_op_t         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);

  // shift amount is the low five bits of b
  logic [4:0] shamt;
  assign shamt = b[4:0];

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      add: begin
        result = a + b;
      end
      sub: begin
        result = a - b;
      end
      sll: begin
        result = a << shamt;
      end
      slt: begin
        result = {{(xlen-1){1'b0}}, lt_signed};
      end
      sltu: begin
        result = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      xor_op: begin
        result = a ^ b;
      end
      srl: begin
        result = a >> shamt;
      end
      sra: begin
        // arithmetic shift keeps the sign of a
        result = $unsigned($signed(a) >>> shamt);
      end
      or_op: begin
        result = a | b;
      end
      and_op: begin
        result = a & b;
      end
      pass_b: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- hw/reg_file.sv
module reg_file
  import rv_pkg::*;
(
  input  logic            clock,

  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  output logic [xlen-1:0] rdata1,
  output logic [xlen-1:0] rdata2,

  input  logic            wen,
  input  logic [4:0]      waddr,
  input  logic [xlen-1:0] wdata
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clock) begin
    if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, x0 always reads zero
  assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

  // the decoder already drops x0 targets, so a write to x0 means
  // the write enable and index went out of step
  a_no_x0_write: assert property (
    @(posedge clock) !(wen && (waddr == 5'd0))
  );

endmodule

//--- hw/inst_decoder.sv
module inst_decoder
  import rv_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,

  input  logic [31:0]           inst,
  input  logic                  ivalid,
  output logic                  iready,

  output logic                  dvalid,
  input  logic                  dready,

  output logic [4:0]            rs1,
  output logic [4:0]            rs2,
  output logic [4:0]            rd,
  output logic [xlen-1:0]       imm,
  output alu_op_t               alu_op,
  output operand_b_sel_t        operand_b_sel,
  output logic                  r_wen
);

  // held copy of the accepted word, decoded fields come from here
  logic [31:0] inst_q;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  logic is_lui;
  logic is_op_imm;
  logic is_op;
  logic f7_base;
  logic f7_alt;

  assign is_lui    = opcode == opcode_lui;
  assign is_op_imm = opcode == opcode_op_imm;
  assign is_op     = opcode == opcode_op;
  assign f7_base   = funct7 == funct7_base;
  assign f7_alt    = funct7 == funct7_alt;

  // funct3 groups shared by op and op-imm
  logic f3_add;
  logic f3_sll;
  logic f3_shr;
  logic f3_other;

  assign f3_add   = funct3 == 3'b000;
  assign f3_sll   = funct3 == 3'b001;
  assign f3_shr   = funct3 == 3'b101;
  assign f3_other = !(f3_add || f3_sll || f3_shr);

  // op-imm: immediate forms are free, shifts need a legal funct7
  logic legal_op_imm;
  assign legal_op_imm = is_op_imm &&
                        (f3_add || f3_other || (f3_sll && f7_base) ||
                         (f3_shr && (f7_base || f7_alt)));

  // op: alternate funct7 only for sub and sra
  logic legal_op;
  assign legal_op = is_op &&
                    (f7_base || (f7_alt && (f3_add || f3_shr)));

  logic supported;
  assign supported = is_lui || legal_op_imm || legal_op;

  // register indices, lui reads x0 so that pass-through sees zero on a
  assign rs1 = is_lui ? 5'd0 : inst_q[19:15];
  assign rs2 = inst_q[24:20];
  assign rd  = inst_q[11:7];

  // u immediate for lui, i immediate otherwise
  assign imm = is_lui ? {inst_q[31:12], 12'b0} : {{20{inst_q[31]}}, inst_q[31:20]};

  assign operand_b_sel = is_op ? reg_b : rv_pkg::imm;

  always_comb begin
    alu_op = add;
    if (is_lui) begin
      alu_op = pass_b;
    end else if (is_op || is_op_imm) begin
      case (funct3)
        3'b000:  alu_op = (is_op && f7_alt) ? sub : add;
        3'b001:  alu_op = sll;
        3'b010:  alu_op = slt;
        3'b011:  alu_op = sltu;
        3'b100:  alu_op = xor_op;
        3'b101:  alu_op = f7_alt ? sra : srl;
        3'b110:  alu_op = or_op;
        default: alu_op = and_op;
      endcase
    end
  end

  // writes to x0 and unsupported words are dropped here
  assign r_wen = supported && (rd != 5'd0);

  // one word at a time, accept then present until taken
  always_ff @(posedge clock) begin
    if (reset) begin
      iready <= 1'b1;
      dvalid <= 1'b0;
    end else if (ivalid && iready) begin
      iready <= 1'b0;
      dvalid <= 1'b1;
    end else if (dvalid && dready) begin
      iready <= 1'b1;
      dvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ivalid && iready) begin
      inst_q <= inst;
    end
  end

  // an offered word stays offered and unchanged until it is taken
  a_host_holds_word: assert property (
    @(posedge clock) disable iff (reset)
      (ivalid && !iready) |=> (ivalid && $stable(inst))
  );

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

  // integer register and datapath width
  localparam int xlen = 32;

  // major opcodes handled by this slice
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  // funct7 splits add/sub and srl/sra
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  // alu operations, pass_b forwards operand b for lui
  typedef enum logic [3:0] {
    add,
    sub,
    sll,
    slt,
    sltu,
    xor_op,
    srl,
    sra,
    or_op,
    and_op,
    pass_b
  } alu_op_t;

  // source of the second alu operand
  typedef enum logic {
    reg_b,
    imm
  } operand_b_sel_t;

endpackage
